/* Makefile */
# Verilator flow for the ALU testbench
VERILATOR ?= verilator
TOP       ?= tb_alu_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS: $(TOP)"; \
	else \
		echo "FAIL: $(TOP), see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alu_adder.sv */
`timescale 1ns/1ps

module alu_adder import alu_pkg::*; (
    input  alu_op_e          operator_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    output logic [XLEN-1:0]  adder_result_o,
    output logic             adder_zero_o,
    output logic [XLEN-1:0]  operand_b_inv_o
);

    logic            negate_b;
    logic [XLEN:0]   adder_in_a;
    logic [XLEN:0]   adder_in_b;
    logic [XLEN:0]   adder_sum;

    // Subtraction, compares and inverted logic ops use ~B
    always_comb begin
        negate_b = 1'b0;
        case (operator_i)
            SUB, EQ, NE,
            ANDN, ORN, XNOR: negate_b = 1'b1;
            default:         negate_b = 1'b0;
        endcase
    end

    // The extra low bit turns the invert flag into the carry-in
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i, 1'b0} ^ {(XLEN + 1){negate_b}};

    assign adder_sum = adder_in_a + adder_in_b;

    assign adder_result_o  = adder_sum[XLEN:1];
    assign adder_zero_o    = ~|adder_sum[XLEN:1];
    assign operand_b_inv_o = adder_in_b[XLEN:1];

endmodule

/* alu_compare.sv */
`timescale 1ns/1ps

module alu_compare import alu_pkg::*; (
    input  alu_op_e          operator_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  logic             adder_zero_i,
    output logic             less_o,
    output logic             branch_res_o
);

    logic signed_cmp;
    logic less;

    // Signed compare for signed ops, unsigned for the rest
    assign signed_cmp = operator_i inside {SLTS, LTS, GES};

    // One extra sign bit covers both forms
    assign less = $signed({signed_cmp & operand_a_i[XLEN-1], operand_a_i})
                < $signed({signed_cmp & operand_b_i[XLEN-1], operand_b_i});

    assign less_o = less;

    // --------------------------------------
    // Branch resolution
    // --------------------------------------
    always_comb begin
        branch_res_o = 1'b1;
        case (operator_i)
            EQ:       branch_res_o = adder_zero_i;
            NE:       branch_res_o = ~adder_zero_i;
            LTS, LTU: branch_res_o = less;
            GES, GEU: branch_res_o = ~less;
            // Not a branch, taken by default
            default:  branch_res_o = 1'b1;
        endcase
    end

endmodule

/* alu_pkg.sv */
package alu_pkg;

    // Operand width and polar SIMD layout
    localparam int XLEN   = 32;
    localparam int LANE_W = 8;
    localparam int LANES  = XLEN / LANE_W;

    // --------------------------------------
    // Operators
    // --------------------------------------
    typedef enum logic [4:0] {
        // Adder and logic
        ADD,
        SUB,
        ANDL,
        ORL,
        XORL,
        ANDN,
        ORN,
        XNOR,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Set less than
        SLTS,
        SLTU,
        // Branch resolution
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // Polar per-lane ops
        PL_R,
        PL_F,
        PL_G,
        // Polar cross-lane ops
        PL_VADDREP1,
        PL_VADDREP2,
        PL_VREPSUM
    } alu_op_e;

    // --------------------------------------
    // Operand word views
    // --------------------------------------
    // Lane 0 and half 0 sit in the low bits
    typedef union packed {
        logic [XLEN-1:0]                 word;
        logic [LANES-1:0][LANE_W-1:0]    lane;
        logic [1:0][XLEN/2-1:0]          half;
    } alu_word_u;

endpackage

/* alu_result_mux.sv */
`timescale 1ns/1ps

module alu_result_mux import alu_pkg::*; (
    input  alu_op_e          operator_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_inv_i,
    input  logic [XLEN-1:0]  adder_result_i,
    input  logic [XLEN-1:0]  shift_result_i,
    input  logic [XLEN-1:0]  polar_result_i,
    input  logic             less_i,
    output logic [XLEN-1:0]  result_o
);

    logic [XLEN-1:0] and_result;
    logic [XLEN-1:0] or_result;
    logic [XLEN-1:0] xor_result;

    // --------------------------------------
    // Logic ops
    // --------------------------------------
    // B is already inverted for ANDN, ORN and XNOR
    assign and_result = operand_a_i & operand_b_inv_i;
    assign or_result  = operand_a_i | operand_b_inv_i;
    assign xor_result = operand_a_i ^ operand_b_inv_i;

    // --------------------------------------
    // Result select
    // --------------------------------------
    always_comb begin
        result_o = '0;
        case (operator_i)
            ANDL, ANDN:    result_o = and_result;
            ORL, ORN:      result_o = or_result;
            XORL, XNOR:    result_o = xor_result;

            ADD, SUB:      result_o = adder_result_i;

            SLL, SRL, SRA: result_o = shift_result_i;

            SLTS, SLTU:    result_o = {{(XLEN - 1){1'b0}}, less_i};

            PL_R, PL_F, PL_G,
            PL_VADDREP1, PL_VADDREP2,
            PL_VREPSUM:    result_o = polar_result_i;

            // Branches only produce a flag
            default:       result_o = '0;
        endcase
    end

endmodule

/* alu_shifter.sv */
`timescale 1ns/1ps

module alu_shifter import alu_pkg::*; (
    input  alu_op_e                    operator_i,
    input  logic [XLEN-1:0]            operand_a_i,
    input  logic [$clog2(XLEN)-1:0]    shamt_i,
    output logic [XLEN-1:0]            shift_result_o
);

    logic            shift_left;
    logic            shift_arith;
    logic [XLEN-1:0] operand_a_rev;
    logic [XLEN-1:0] shift_in;
    logic [XLEN:0]   shift_in_ext;
    logic [XLEN-1:0] shift_right;
    logic [XLEN-1:0] shift_right_rev;

    assign shift_left  = (operator_i == SLL);
    assign shift_arith = (operator_i == SRA);

    // --------------------------------------
    // Left shift as reversed right shift
    // --------------------------------------
    for (genvar k = 0; k < XLEN; k++) begin : gen_rev_in
        assign operand_a_rev[k] = operand_a_i[XLEN-1-k];
    end

    assign shift_in = shift_left ? operand_a_rev : operand_a_i;

    // Sign fill only for SRA, zero fill otherwise
    assign shift_in_ext = {shift_arith & shift_in[XLEN-1], shift_in};
    assign shift_right  = XLEN'($unsigned($signed(shift_in_ext) >>> shamt_i));

    for (genvar k = 0; k < XLEN; k++) begin : gen_rev_out
        assign shift_right_rev[k] = shift_right[XLEN-1-k];
    end

    assign shift_result_o = shift_left ? shift_right_rev : shift_right;

endmodule

/* alu_top.sv */
`timescale 1ns/1ps

module alu_top import alu_pkg::*; (
    input  alu_op_e          operator_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  logic [XLEN-1:0]  imm_i,
    output logic [XLEN-1:0]  result_o,
    output logic             branch_res_o
);

    logic [XLEN-1:0] adder_result;
    logic            adder_zero;
    logic [XLEN-1:0] operand_b_inv;
    logic [XLEN-1:0] shift_result;
    logic            less;
    logic [XLEN-1:0] polar_result;

    alu_adder u_alu_adder (
        .operator_i      (operator_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .adder_result_o  (adder_result),
        .adder_zero_o    (adder_zero),
        .operand_b_inv_o (operand_b_inv)
    );

    // Shift amount from the low bits of B
    alu_shifter u_alu_shifter (
        .operator_i      (operator_i),
        .operand_a_i     (operand_a_i),
        .shamt_i         (operand_b_i[$clog2(XLEN)-1:0]),
        .shift_result_o  (shift_result)
    );

    alu_compare u_alu_compare (
        .operator_i      (operator_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .adder_zero_i    (adder_zero),
        .less_o          (less),
        .branch_res_o    (branch_res_o)
    );

    polar_unit u_polar_unit (
        .operator_i      (operator_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .imm_i           (imm_i),
        .polar_result_o  (polar_result)
    );

    alu_result_mux u_alu_result_mux (
        .operator_i      (operator_i),
        .operand_a_i     (operand_a_i),
        .operand_b_inv_i (operand_b_inv),
        .adder_result_i  (adder_result),
        .shift_result_i  (shift_result),
        .polar_result_i  (polar_result),
        .less_i          (less),
        .result_o        (result_o)
    );

endmodule

/* polar_lane.sv */
`timescale 1ns/1ps

module polar_lane #(
    parameter int LANE_W = 8
) (
    input  logic [LANE_W-1:0]  a_i,
    input  logic [LANE_W-1:0]  b_i,
    input  logic [LANE_W-1:0]  imm_i,
    input  logic               r_flag_i,
    output logic [LANE_W-1:0]  r_o,
    output logic [LANE_W-1:0]  f_o,
    output logic [LANE_W-1:0]  g_o
);

    // Symmetric saturation bound, 127 for a byte lane
    localparam logic signed [LANE_W:0] SAT_POS = (2 ** (LANE_W - 1)) - 1;
    localparam logic signed [LANE_W:0] SAT_NEG = -SAT_POS;

    logic                     a_neg;
    logic                     b_neg;
    logic [LANE_W-1:0]        abs_a;
    logic [LANE_W-1:0]        abs_b;
    logic [LANE_W-1:0]        min_abs;
    logic signed [LANE_W:0]   a_ext;
    logic signed [LANE_W:0]   b_ext;
    logic signed [LANE_W:0]   sum;
    logic signed [LANE_W:0]   diff;
    logic signed [LANE_W:0]   g_raw;

    assign a_neg = a_i[LANE_W-1];
    assign b_neg = b_i[LANE_W-1];

    // R: sign of a, forced to zero by the flag
    assign r_o = r_flag_i ? '0 : LANE_W'(a_neg);

    // --------------------------------------
    // F: smaller magnitude with product sign
    // --------------------------------------
    // Unsigned magnitudes, so -128 maps to 128
    assign abs_a   = a_neg ? -a_i : a_i;
    assign abs_b   = b_neg ? -b_i : b_i;
    assign min_abs = (abs_b < abs_a) ? abs_b : abs_a;
    assign f_o     = (a_neg ^ b_neg) ? -min_abs : min_abs;

    // --------------------------------------
    // G: saturating add or sub
    // --------------------------------------
    assign a_ext = {a_neg, a_i};
    assign b_ext = {b_neg, b_i};
    assign sum   = a_ext + b_ext;
    assign diff  = b_ext - a_ext;
    assign g_raw = (imm_i == '0) ? sum : diff;

    assign g_o = (g_raw > SAT_POS) ? SAT_POS[LANE_W-1:0] :
                 (g_raw < SAT_NEG) ? SAT_NEG[LANE_W-1:0] :
                                     g_raw[LANE_W-1:0];

endmodule

/* polar_unit.sv */
`timescale 1ns/1ps

module polar_unit import alu_pkg::*; (
    input  alu_op_e          operator_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  logic [XLEN-1:0]  imm_i,
    output logic [XLEN-1:0]  polar_result_o
);

    localparam int HALF_W = XLEN / 2;

    alu_word_u                     op_a;
    alu_word_u                     op_b;
    alu_word_u                     op_imm;
    alu_word_u                     addrep1;
    alu_word_u                     addrep2;
    alu_word_u                     repsum;
    logic                          r_flag;
    logic [LANES-1:0][LANE_W-1:0]  lane_r;
    logic [LANES-1:0][LANE_W-1:0]  lane_f;
    logic [LANES-1:0][LANE_W-1:0]  lane_g;

    assign op_a.word   = operand_a_i;
    assign op_b.word   = operand_b_i;
    assign op_imm.word = imm_i;

    // Shared by all lanes
    assign r_flag = (op_b.lane[0] == LANE_W'(1));

    for (genvar i = 0; i < LANES; i++) begin : gen_lane
        polar_lane #(
            .LANE_W   (LANE_W)
        ) u_polar_lane (
            .a_i      (op_a.lane[i]),
            .b_i      (op_b.lane[i]),
            .imm_i    (op_imm.lane[i]),
            .r_flag_i (r_flag),
            .r_o      (lane_r[i]),
            .f_o      (lane_f[i]),
            .g_o      (lane_g[i])
        );
    end

    // --------------------------------------
    // Cross-lane ops
    // --------------------------------------
    // Halfword plus sign-extended byte, wrapping at 16 bits
    always_comb begin
        addrep1.half[1] = op_a.half[1] + HALF_W'($signed(op_b.lane[1]));
        addrep1.half[0] = op_a.half[0] + HALF_W'($signed(op_b.lane[0]));
        addrep2.half[1] = op_a.half[1] + HALF_W'($signed(op_b.lane[3]));
        addrep2.half[0] = op_a.half[0] + HALF_W'($signed(op_b.lane[2]));

        // One sign byte per halfword
        repsum.lane[3] = LANE_W'(op_b.half[1][HALF_W-1]);
        repsum.lane[2] = LANE_W'(op_b.half[0][HALF_W-1]);
        repsum.lane[1] = LANE_W'(op_a.half[1][HALF_W-1]);
        repsum.lane[0] = LANE_W'(op_a.half[0][HALF_W-1]);
    end

    always_comb begin
        case (operator_i)
            PL_R:        polar_result_o = lane_r;
            PL_F:        polar_result_o = lane_f;
            PL_G:        polar_result_o = lane_g;
            PL_VADDREP1: polar_result_o = addrep1.word;
            PL_VADDREP2: polar_result_o = addrep2.word;
            PL_VREPSUM:  polar_result_o = repsum.word;
            default:     polar_result_o = '0;
        endcase
    end

endmodule

/* tb_alu_ref.svh */
`ifndef TB_ALU_REF_SVH
`define TB_ALU_REF_SVH

// Expected {branch flag, result} for one operation
function automatic logic [XLEN:0] alu_ref(input alu_op_e op, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b,
                                          input logic [XLEN-1:0] c);
    logic [XLEN-1:0] res;
    logic            br;
    logic [15:0]     hi;
    logic [15:0]     lo;
    int              sh;
    int              sa;
    int              sb;
    int              mag_a;
    int              mag_b;
    int              v;
    int              sat;
    res = '0;
    br  = 1'b1;
    sh  = int'(b[4:0]);
    sat = (2 ** (LANE_W - 1)) - 1;
    case (op)
        ADD:  res = a + b;
        SUB:  res = a - b;
        ANDL: res = a & b;
        ORL:  res = a | b;
        XORL: res = a ^ b;
        ANDN: res = a & ~b;
        ORN:  res = a | ~b;
        XNOR: res = ~(a ^ b);
        SLL:  res = a << sh;
        SRL:  res = a >> sh;
        SRA:  res = $signed(a) >>> sh;
        SLTS: res = {31'b0, ($signed(a) < $signed(b))};
        SLTU: res = {31'b0, (a < b)};
        EQ:   br = (a == b);
        NE:   br = (a != b);
        LTS:  br = ($signed(a) < $signed(b));
        LTU:  br = (a < b);
        GES:  br = ($signed(a) >= $signed(b));
        GEU:  br = (a >= b);
        PL_R, PL_F, PL_G: begin
            for (int i = 0; i < LANES; i++) begin
                sa = int'($signed(a[LANE_W*i +: LANE_W]));
                sb = int'($signed(b[LANE_W*i +: LANE_W]));
                mag_a = (sa < 0) ? -sa : sa;
                mag_b = (sb < 0) ? -sb : sb;
                if (op == PL_R) begin
                    v = (b[LANE_W-1:0] == 8'h01) ? 0 : ((sa < 0) ? 1 : 0);
                end else if (op == PL_F) begin
                    v = (mag_b < mag_a) ? mag_b : mag_a;
                    if ((sa < 0) != (sb < 0))
                        v = -v;
                end else begin
                    v = (c[LANE_W*i +: LANE_W] == 8'h00) ? sa + sb : sb - sa;
                    // Clamp to the symmetric bound
                    v = (v > sat) ? sat : ((v < -sat) ? -sat : v);
                end
                res[LANE_W*i +: LANE_W] = LANE_W'(v);
            end
        end
        PL_VADDREP1: begin
            hi  = a[31:16] + {{8{b[15]}}, b[15:8]};
            lo  = a[15:0] + {{8{b[7]}}, b[7:0]};
            res = {hi, lo};
        end
        PL_VADDREP2: begin
            hi  = a[31:16] + {{8{b[31]}}, b[31:24]};
            lo  = a[15:0] + {{8{b[23]}}, b[23:16]};
            res = {hi, lo};
        end
        PL_VREPSUM: res = {7'b0, b[31], 7'b0, b[15], 7'b0, a[31], 7'b0, a[15]};
        default:    res = '0;
    endcase
    return {br, res};
endfunction

`endif

/* tb_alu_top.sv */
`timescale 1ns/1ps

module tb_alu_top import alu_pkg::*; ();

    localparam int CLK_HALF      = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int CHECK_TIMEOUT = 8;
    localparam int SIM_LIMIT     = 1000000;

    logic            clk;
    logic            rst_n;
    alu_op_e         operator;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] result;
    logic            branch_res;

    logic            check_en;
    logic [XLEN:0]   expected;
    integer          seed;
    string           test_name;
    int              checks_issued;
    int              checks_done;
    int              error_count;
    int              tests_run;
    int              tests_failed;
    int              err_start;
    int              chk_start;
    logic            timeout_seen;

    `include "tb_alu_ref.svh"

    alu_top UUT (
        .operator_i   (operator),
        .operand_a_i  (operand_a),
        .operand_b_i  (operand_b),
        .imm_i        (imm),
        .result_o     (result),
        .branch_res_o (branch_res)
    );

    always #(CLK_HALF) clk = ~clk;

    // ----------------------------------------
    // Compare process
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst_n && check_en) begin
            expected = alu_ref(operator, operand_a, operand_b, imm);
            if (result !== expected[XLEN-1:0] || branch_res !== expected[XLEN]) begin
                $display("** Error %s: %s a=%h b=%h imm=%h expected %h/%b actual %h/%b",
                         test_name, operator.name(), operand_a, operand_b, imm,
                         expected[XLEN-1:0], expected[XLEN], result, branch_res);
                error_count++;
            end
            checks_done++;
        end
    end

    function automatic logic [XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    // New inputs on the falling edge and a check on the next rising edge
    task automatic apply(input alu_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] c);
        @(negedge clk);
        operator  = op;
        operand_a = a;
        operand_b = b;
        imm       = c;
        check_en  = 1'b1;
        checks_issued++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = error_count;
        chk_start = checks_issued;
    endtask

    task automatic finish_test();
        int cycles;
        @(negedge clk);
        check_en = 1'b0;
        cycles   = 0;
        while (checks_done != checks_issued && cycles < CHECK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (checks_done != checks_issued) begin
            $display("%s: compare process checked only %0d of %0d vectors",
                     test_name, checks_done, checks_issued);
            timeout_seen = 1'b1;
        end
        tests_run++;
        if (error_count != err_start)
            tests_failed++;
        $display("Test %s done: %0d vectors, %0d errors", test_name,
                 checks_issued - chk_start, error_count - err_start);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_adder_logic();
        alu_op_e ops[8];
        ops = '{ADD, SUB, ANDL, ORL, XORL, ANDN, ORN, XNOR};
        start_test("adder_logic");
        foreach (ops[i]) begin
            for (int n = 0; n < 16; n++)
                apply(ops[i], rand_word(), rand_word(), rand_word());
            // Carry out and signed overflow corners
            apply(ops[i], 32'hFFFF_FFFF, 32'h0000_0001, '0);
            apply(ops[i], 32'h7FFF_FFFF, 32'h0000_0001, '0);
            apply(ops[i], 32'h8000_0000, 32'h7FFF_FFFF, '0);
            apply(ops[i], 32'h8000_0000, 32'h8000_0000, '0);
        end
        finish_test();
    endtask

    task automatic test_shifts();
        alu_op_e         ops[3];
        logic [XLEN-1:0] r;
        ops = '{SLL, SRL, SRA};
        start_test("shifts");
        foreach (ops[i]) begin
            for (int sh = 0; sh < XLEN; sh++) begin
                // Upper bits of B are noise
                r = rand_word();
                apply(ops[i], rand_word(), {r[XLEN-1:5], 5'(sh)}, '0);
                r = rand_word();
                apply(ops[i], rand_word() | 32'h8000_0000, {r[XLEN-1:5], 5'(sh)}, rand_word());
            end
        end
        finish_test();
    endtask

    task automatic test_compares();
        alu_op_e         ops[8];
        logic [XLEN-1:0] r;
        ops = '{SLTS, SLTU, EQ, NE, LTS, LTU, GES, GEU};
        start_test("compares");
        foreach (ops[i]) begin
            for (int n = 0; n < 8; n++) begin
                r = rand_word();
                apply(ops[i], rand_word(), r, '0);
                apply(ops[i], r, r, '0);
                // Same low bits with the opposite sign
                apply(ops[i], r, r ^ 32'h8000_0000, '0);
            end
            apply(ops[i], '0, 32'hFFFF_FFFF, '0);
            apply(ops[i], 32'h8000_0000, 32'h7FFF_FFFF, '0);
        end
        finish_test();
    endtask

    task automatic test_polar_lane();
        logic [LANE_W-1:0] vals[6];
        alu_word_u         wa;
        alu_word_u         wb;
        alu_word_u         wi;
        vals = '{8'h80, 8'hFF, 8'h00, 8'h7F, 8'h01, 8'h81};
        start_test("polar_lane");
        for (int n = 0; n < 8; n++) begin
            wb.word    = rand_word();
            wb.lane[0] = 8'h01;
            apply(PL_R, rand_word(), wb.word, '0);
            wb.word = rand_word();
            if (wb.lane[0] == 8'h01)
                wb.lane[0] = 8'h02;
            apply(PL_R, rand_word(), wb.word, '0);
            apply(PL_F, rand_word(), rand_word(), '0);
            apply(PL_G, rand_word(), rand_word(), rand_word() & 32'hFF00_FF00);
        end
        // Every pair of edge values rotated through the lanes
        for (int x = 0; x < 6; x++) begin
            for (int y = 0; y < 6; y++) begin
                for (int k = 0; k < LANES; k++) begin
                    wa.lane[k] = vals[(x + k) % 6];
                    wb.lane[k] = vals[(y + k) % 6];
                    wi.lane[k] = ((x + y + k) % 2 == 0) ? 8'h00 : 8'hA5;
                end
                apply(PL_F, wa.word, wb.word, '0);
                apply(PL_G, wa.word, wb.word, wi.word);
            end
        end
        finish_test();
    endtask

    task automatic test_polar_cross();
        alu_op_e           ops[3];
        logic [15:0]       edge_halves[4];
        logic [LANE_W-1:0] edge_bytes[4];
        alu_word_u         wa;
        alu_word_u         wb;
        ops         = '{PL_VADDREP1, PL_VADDREP2, PL_VREPSUM};
        edge_halves = '{16'h0000, 16'h7FFF, 16'h8000, 16'hFFFF};
        edge_bytes  = '{8'h7F, 8'h80, 8'hFF, 8'h01};
        start_test("polar_cross");
        foreach (ops[i]) begin
            for (int n = 0; n < 8; n++)
                apply(ops[i], rand_word(), rand_word(), rand_word());
            for (int x = 0; x < 4; x++) begin
                for (int y = 0; y < 4; y++) begin
                    wa.half[1] = edge_halves[x];
                    wa.half[0] = edge_halves[y];
                    for (int k = 0; k < LANES; k++)
                        wb.lane[k] = edge_bytes[(x + y + k) % 4];
                    apply(ops[i], wa.word, wb.word, '0);
                end
            end
        end
        finish_test();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed          = 92831;
        clk           = 1'b0;
        rst_n         = 1'b0;
        check_en      = 1'b0;
        operator      = ADD;
        operand_a     = '0;
        operand_b     = '0;
        imm           = '0;
        test_name     = "reset";
        timeout_seen  = 1'b0;
        tests_run     = 0;
        tests_failed  = 0;
        checks_issued = 0;
        // Reset only holds off the first vectors
        for (int n = 0; n < RESET_CYCLES; n++)
            @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_adder_logic();
        test_shifts();
        test_compares();
        test_polar_lane();
        test_polar_cross();

        $display("Summary: %0d tests, %0d failed, %0d vectors, %0d errors",
                 tests_run, tests_failed, checks_issued, error_count);
        if (error_count == 0 && !timeout_seen) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(SIM_LIMIT);
        $display("Simulation did not finish within %0d ns", SIM_LIMIT);
        $display("Errors found");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
alu_pkg.sv
alu_adder.sv
alu_shifter.sv
alu_compare.sv
polar_lane.sv
polar_unit.sv
alu_result_mux.sv
alu_top.sv
tb_alu_top.sv
